/* rtl/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    typedef logic [31:0] xlen_t;        // Register data, PC, immediate
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [1:0]  alu_src_sel_t; // [1] imm as operand b, [0] pc as operand a

    typedef enum logic [1:0] {
        DB,                             // Byte
        DH,                             // Halfword
        DW                              // Word
    } data_width_e;

    typedef enum logic [2:0] {
        R,
        I,
        S,
        B,
        U,
        J,
        NONE
    } instr_fmt_e;

    // Major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB and SRA/SRAI
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // ALU func3, shared by OP_IMM and OP_REG
    localparam func3_t F3_ADD  = 3'd0;
    localparam func3_t F3_SLL  = 3'd1;
    localparam func3_t F3_SLT  = 3'd2;
    localparam func3_t F3_SLTU = 3'd3;
    localparam func3_t F3_XOR  = 3'd4;
    localparam func3_t F3_SRL  = 3'd5;
    localparam func3_t F3_OR   = 3'd6;
    localparam func3_t F3_AND  = 3'd7;

    localparam func3_t F3_BEQ  = 3'd0;
    localparam func3_t F3_BNE  = 3'd1;
    localparam func3_t F3_BLT  = 3'd4;
    localparam func3_t F3_BGE  = 3'd5;
    localparam func3_t F3_BLTU = 3'd6;
    localparam func3_t F3_BGEU = 3'd7;

    // Load and store widths, low two bits give the access size
    localparam func3_t F3_BYTE   = 3'd0;
    localparam func3_t F3_HALF   = 3'd1;
    localparam func3_t F3_WORD   = 3'd2;
    localparam func3_t F3_BYTE_U = 3'd4;
    localparam func3_t F3_HALF_U = 3'd5;

    localparam func3_t F3_MUL    = 3'd0;
    localparam func3_t F3_MULH   = 3'd1;
    localparam func3_t F3_MULHSU = 3'd2;
    localparam func3_t F3_MULHU  = 3'd3;
    localparam func3_t F3_DIV    = 3'd4;
    localparam func3_t F3_DIVU   = 3'd5;
    localparam func3_t F3_REM    = 3'd6;
    localparam func3_t F3_REMU   = 3'd7;

    typedef struct packed {
        logic        w;                    // Writes rd
        logic        l;                    // Load
        logic        s;                    // Store
        logic        b;                    // Conditional branch
        logic        j;                    // Jump, JAL or JALR
        logic        a;                    // ALU result goes to rd
        logic        m;                    // Multiply or divide unit
        logic        sign;                 // Signed compare or subtract/arith shift
        logic        sign_ex;              // Sign extend load data
        logic        ignore_first_operand; // LUI, operand a forced to zero
        logic        illegal;
        data_width_e dw;
    } ctrl_t;

    typedef struct packed {
        ctrl_t        ctrl;
        xlen_t        imm;
        alu_src_sel_t alu_src_sel;
        func3_t       func3;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        xlen_t        rs1_val;
        xlen_t        rs2_val;
        xlen_t        pc;
    } decoded_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  rv_decode_pkg::instr_t   instr,
    output rv_decode_pkg::decoded_t dec
);

    logic [6:0]                   f7;
    rv_decode_pkg::func3_t        f3;
    rv_decode_pkg::opcode_t       opcode;
    rv_decode_pkg::ctrl_t         ctrl;
    rv_decode_pkg::instr_fmt_e    fmt;
    rv_decode_pkg::xlen_t         imm;
    rv_decode_pkg::alu_src_sel_t  alu_src_sel;

    assign f7     = instr[31:25];
    assign f3     = instr[14:12];
    assign opcode = instr[6:0];

    always_comb begin
        ctrl = '0;
        fmt  = rv_decode_pkg::NONE;
        casez ({f7, f3, opcode})
            {7'b???????, 3'b???, rv_decode_pkg::OP_LUI}: begin
                ctrl.w                    = 1'b1;
                ctrl.ignore_first_operand = 1'b1;
                fmt                       = rv_decode_pkg::U;
            end
            {7'b???????, 3'b???, rv_decode_pkg::OP_AUIPC}: begin
                ctrl.w = 1'b1;
                fmt    = rv_decode_pkg::U;
            end
            {7'b???????, 3'b???, rv_decode_pkg::OP_JAL}: begin
                ctrl.w = 1'b1;
                ctrl.j = 1'b1;
                fmt    = rv_decode_pkg::J;
            end
            {7'b???????, 3'b000, rv_decode_pkg::OP_JALR}: begin
                ctrl.w = 1'b1;
                ctrl.j = 1'b1;
                fmt    = rv_decode_pkg::I;
            end
            {7'b???????, rv_decode_pkg::F3_BEQ,  rv_decode_pkg::OP_BRANCH},
            {7'b???????, rv_decode_pkg::F3_BNE,  rv_decode_pkg::OP_BRANCH},
            {7'b???????, rv_decode_pkg::F3_BLT,  rv_decode_pkg::OP_BRANCH},
            {7'b???????, rv_decode_pkg::F3_BGE,  rv_decode_pkg::OP_BRANCH},
            {7'b???????, rv_decode_pkg::F3_BLTU, rv_decode_pkg::OP_BRANCH},
            {7'b???????, rv_decode_pkg::F3_BGEU, rv_decode_pkg::OP_BRANCH}: begin
                ctrl.b    = 1'b1;
                ctrl.sign = 1'b1; // Compare through the subtractor
                fmt       = rv_decode_pkg::B;
            end
            {7'b???????, rv_decode_pkg::F3_BYTE, rv_decode_pkg::OP_LOAD},
            {7'b???????, rv_decode_pkg::F3_HALF, rv_decode_pkg::OP_LOAD},
            {7'b???????, rv_decode_pkg::F3_WORD, rv_decode_pkg::OP_LOAD}: begin
                ctrl.l       = 1'b1;
                ctrl.w       = 1'b1;
                ctrl.sign_ex = 1'b1;
                fmt          = rv_decode_pkg::I;
            end
            {7'b???????, rv_decode_pkg::F3_BYTE_U, rv_decode_pkg::OP_LOAD},
            {7'b???????, rv_decode_pkg::F3_HALF_U, rv_decode_pkg::OP_LOAD}: begin
                ctrl.l = 1'b1;
                ctrl.w = 1'b1;
                fmt    = rv_decode_pkg::I;
            end
            {7'b???????, rv_decode_pkg::F3_BYTE, rv_decode_pkg::OP_STORE},
            {7'b???????, rv_decode_pkg::F3_HALF, rv_decode_pkg::OP_STORE},
            {7'b???????, rv_decode_pkg::F3_WORD, rv_decode_pkg::OP_STORE}: begin
                ctrl.s = 1'b1;
                fmt    = rv_decode_pkg::S;
            end
            {7'b???????, rv_decode_pkg::F3_ADD, rv_decode_pkg::OP_IMM},
            {7'b???????, rv_decode_pkg::F3_XOR, rv_decode_pkg::OP_IMM},
            {7'b???????, rv_decode_pkg::F3_OR,  rv_decode_pkg::OP_IMM},
            {7'b???????, rv_decode_pkg::F3_AND, rv_decode_pkg::OP_IMM},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SLL, rv_decode_pkg::OP_IMM},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SRL, rv_decode_pkg::OP_IMM}: begin
                ctrl.w = 1'b1;
                ctrl.a = 1'b1;
                fmt    = rv_decode_pkg::I;
            end
            {7'b???????, rv_decode_pkg::F3_SLT,  rv_decode_pkg::OP_IMM},
            {7'b???????, rv_decode_pkg::F3_SLTU, rv_decode_pkg::OP_IMM},
            {rv_decode_pkg::F7_ALT, rv_decode_pkg::F3_SRL, rv_decode_pkg::OP_IMM}: begin
                ctrl.w    = 1'b1;
                ctrl.a    = 1'b1;
                ctrl.sign = 1'b1;
                fmt       = rv_decode_pkg::I;
            end
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_ADD, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SLL, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_XOR, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SRL, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_OR,  rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_AND, rv_decode_pkg::OP_REG}: begin
                ctrl.w = 1'b1;
                ctrl.a = 1'b1;
                fmt    = rv_decode_pkg::R;
            end
            {rv_decode_pkg::F7_ALT,  rv_decode_pkg::F3_ADD,  rv_decode_pkg::OP_REG}, // SUB
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SLT,  rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_BASE, rv_decode_pkg::F3_SLTU, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_ALT,  rv_decode_pkg::F3_SRL,  rv_decode_pkg::OP_REG}: begin
                ctrl.w    = 1'b1;
                ctrl.a    = 1'b1;
                ctrl.sign = 1'b1;
                fmt       = rv_decode_pkg::R;
            end
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_MUL,    rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_MULH,   rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_MULHSU, rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_MULHU,  rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_DIV,    rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_DIVU,   rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_REM,    rv_decode_pkg::OP_REG},
            {rv_decode_pkg::F7_MULDIV, rv_decode_pkg::F3_REMU,   rv_decode_pkg::OP_REG}: begin
                ctrl.w = 1'b1;
                ctrl.m = 1'b1;
                fmt    = rv_decode_pkg::R;
            end
            default: begin
                ctrl.illegal = 1'b1; // Unknown word becomes a NOP
            end
        endcase
        if (ctrl.l || ctrl.s) begin
            case (f3[1:0])
                2'b00:   ctrl.dw = rv_decode_pkg::DB;
                2'b01:   ctrl.dw = rv_decode_pkg::DH;
                default: ctrl.dw = rv_decode_pkg::DW;
            endcase
        end
    end

    always_comb begin
        case (fmt)
            rv_decode_pkg::I: begin
                imm         = {{20{instr[31]}}, instr[31:20]};
                alu_src_sel = 2'b10;
            end
            rv_decode_pkg::S: begin
                imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                alu_src_sel = 2'b10;
            end
            rv_decode_pkg::B: begin
                imm         = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                alu_src_sel = 2'b00; // Target adder takes imm, ALU compares registers
            end
            rv_decode_pkg::U: begin
                imm         = {instr[31:12], 12'b0};
                alu_src_sel = 2'b11;
            end
            rv_decode_pkg::J: begin
                imm         = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                alu_src_sel = 2'b11;
            end
            default: begin
                imm         = '0; // R format and NOP
                alu_src_sel = 2'b00;
            end
        endcase
    end

    assign dec = '{
        ctrl:        ctrl,
        imm:         imm,
        alu_src_sel: alu_src_sel,
        func3:       f3,
        rd:          instr[11:7],
        rs1:         instr[19:15],
        rs2:         instr[24:20],
        rs1_val:     '0,
        rs2_val:     '0,
        pc:          '0
    };

    // Case table sanity, no word both stores and writes rd or loads and branches
    always_comb begin
        assert (!(dec.ctrl.s && dec.ctrl.w) && !(dec.ctrl.l && dec.ctrl.b))
            else $error("instr_decoder: conflicting control flags for %h", instr);
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_decode_pkg::wb_t    wb,
    input  rv_decode_pkg::reg_idx_t rs1,
    input  rv_decode_pkg::reg_idx_t rs2,
    output rv_decode_pkg::xlen_t  rs1_val,
    output rv_decode_pkg::xlen_t  rs2_val
);

    rv_decode_pkg::xlen_t regs [32];
    logic                 we;

    assign we = wb.en && (wb.rd != '0); // Writes to x0 are dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    function automatic rv_decode_pkg::xlen_t read_port(input rv_decode_pkg::reg_idx_t idx);
        rv_decode_pkg::xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we && (wb.rd == idx)) begin
            val = wb.data;   // Same-cycle writeback bypass
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    // x0 storage never picks up a value, whatever writeback does
    assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("reg_file: x0 holds %h", regs[0]);

endmodule

`default_nettype wire

/* rtl/id_ex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_decode_pkg::decoded_t d,
    input  logic                    d_valid,
    input  logic                    stall,
    input  logic                    flush,
    input  rv_decode_pkg::wb_t      wb,
    output rv_decode_pkg::decoded_t q,
    output logic                    q_valid
);

    logic wb_hit;

    assign wb_hit = wb.en && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            q       <= '0;
            q_valid <= 1'b0;
        end else begin
            if (flush) begin
                q_valid <= 1'b0;    // Flush wins over stall
            end else if (!stall) begin
                q_valid <= d_valid;
            end

            if (!stall) begin
                q <= d;
            end else begin
                // Held entry must not miss a result written while it waits
                if (wb_hit && (wb.rd == q.rs1)) begin
                    q.rs1_val <= wb.data;
                end
                if (wb_hit && (wb.rd == q.rs2)) begin
                    q.rs2_val <= wb.data;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (stall && !flush && !wb_hit) |=> ($stable(q) && $stable(q_valid)))
        else $error("id_ex_reg: entry changed during a quiet stall");

endmodule

`default_nettype wire

/* rtl/decode_top.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_top (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_decode_pkg::instr_t   instr,
    input  rv_decode_pkg::xlen_t    pc,
    input  logic                    instr_valid,
    input  logic                    stall,
    input  logic                    flush,
    input  rv_decode_pkg::wb_t      wb,
    output rv_decode_pkg::decoded_t ex,
    output logic                    ex_valid
);

    rv_decode_pkg::decoded_t dec;       // Decoder result, operands still zero
    rv_decode_pkg::decoded_t id_bundle; // Full bundle into ID/EX
    rv_decode_pkg::xlen_t    rs1_val;
    rv_decode_pkg::xlen_t    rs2_val;

    instr_decoder instr_decoder_inst (
        .instr (instr),
        .dec   (dec)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    assign id_bundle = '{
        ctrl:        dec.ctrl,
        imm:         dec.imm,
        alu_src_sel: dec.alu_src_sel,
        func3:       dec.func3,
        rd:          dec.rd,
        rs1:         dec.rs1,
        rs2:         dec.rs2,
        rs1_val:     rs1_val,
        rs2_val:     rs2_val,
        pc:          pc
    };

    id_ex_reg id_ex_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .d       (id_bundle),
        .d_valid (instr_valid),
        .stall   (stall),
        .flush   (flush),
        .wb      (wb),
        .q       (ex),
        .q_valid (ex_valid)
    );

endmodule

`default_nettype wire

/* tests/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0] lfsr_state = 32'd76086;
logic [31:0] shadow [32];              // Architectural register state as the TB sees it

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

function automatic int rand_pct();
    return int'(rand_bits(7) % 32'd100);
endfunction

// Read with same-cycle writeback bypass, x0 is always zero
function automatic logic [31:0] model_read(input logic [4:0] idx, input rv_decode_pkg::wb_t w);
    logic [31:0] v;
    if (idx == 5'd0) begin
        v = '0;
    end else if (w.en && (w.rd == idx)) begin
        v = w.data;
    end else begin
        v = shadow[idx];
    end
    return v;
endfunction

// Reference decode from the ISA tables, fmt 0 none 1 R 2 I 3 S 4 B 5 U 6 J
function automatic rv_decode_pkg::decoded_t model_decode(input logic [31:0] w);
    rv_decode_pkg::decoded_t d;
    logic [2:0] f3;
    logic [6:0] f7;
    int         fmt;
    logic       alu;
    logic       sgn;
    f3  = w[14:12];
    f7  = w[31:25];
    d   = '0;
    fmt = 0;
    alu = 1'b0;
    sgn = 1'b0;
    case (w[6:0])
        7'b0110111: begin                 // LUI
            d.ctrl.w = 1'b1;
            d.ctrl.ignore_first_operand = 1'b1;
            fmt = 5;
        end
        7'b0010111: begin                 // AUIPC
            d.ctrl.w = 1'b1;
            fmt = 5;
        end
        7'b1101111: begin                 // JAL
            d.ctrl.w = 1'b1;
            d.ctrl.j = 1'b1;
            fmt = 6;
        end
        7'b1100111: begin
            if (f3 == 3'd0) begin
                d.ctrl.w = 1'b1;
                d.ctrl.j = 1'b1;
                fmt = 2;
            end
        end
        7'b1100011: begin
            if (f3 != 3'd2 && f3 != 3'd3) begin
                d.ctrl.b = 1'b1;
                d.ctrl.sign = 1'b1;
                fmt = 4;
            end
        end
        7'b0000011: begin
            if (f3 <= 3'd2 || f3 == 3'd4 || f3 == 3'd5) begin
                d.ctrl.l = 1'b1;
                d.ctrl.w = 1'b1;
                d.ctrl.sign_ex = !f3[2];
                fmt = 2;
            end
        end
        7'b0100011: begin
            if (f3 <= 3'd2) begin
                d.ctrl.s = 1'b1;
                fmt = 3;
            end
        end
        7'b0010011: begin
            alu = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
            sgn = (f3 == 3'd2) || (f3 == 3'd3) || (f3 == 3'd5 && f7 == 7'h20);
            fmt = alu ? 2 : 0;
        end
        7'b0110011: begin
            if (f7 == 7'h01) begin
                d.ctrl.w = 1'b1;
                d.ctrl.m = 1'b1;
                fmt = 1;
            end else begin
                alu = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                sgn = f7 == 7'h20 || f3 == 3'd2 || f3 == 3'd3;
                fmt = alu ? 1 : 0;
            end
        end
        default: fmt = 0;
    endcase
    if (alu) begin
        d.ctrl.w = 1'b1;
        d.ctrl.a = 1'b1;
        d.ctrl.sign = sgn;
    end
    if (fmt == 0) begin
        d.ctrl.illegal = 1'b1;
    end
    if (d.ctrl.l || d.ctrl.s) begin
        d.ctrl.dw = (f3[1:0] == 2'd0) ? rv_decode_pkg::DB :
                    (f3[1:0] == 2'd1) ? rv_decode_pkg::DH : rv_decode_pkg::DW;
    end
    case (fmt)
        2: d.imm = {{20{w[31]}}, w[31:20]};
        3: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        4: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        5: d.imm = {w[31:12], 12'b0};
        6: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default: d.imm = '0;
    endcase
    d.alu_src_sel = (fmt == 2 || fmt == 3) ? 2'b10 : (fmt >= 5) ? 2'b11 : 2'b00;
    d.func3 = f3;
    d.rd    = w[11:7];
    d.rs1   = w[19:15];
    d.rs2   = w[24:20];
    return d;
endfunction

`endif

/* tests/tb_decode_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_decode_top;

    logic                    clk;
    logic                    rst;
    rv_decode_pkg::instr_t   instr;
    rv_decode_pkg::xlen_t    pc;
    logic                    instr_valid;
    logic                    stall;
    logic                    flush;
    rv_decode_pkg::wb_t      wb;
    rv_decode_pkg::decoded_t ex;
    logic                    ex_valid;

    rv_decode_pkg::decoded_t exp_q;     // One-entry model of ID/EX
    logic                    exp_valid;
    int                      errors;
    int                      checks;

    `include "decode_model.svh"

    decode_top decode_top_inst (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .stall       (stall),
        .flush       (flush),
        .wb          (wb),
        .ex          (ex),
        .ex_valid    (ex_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic compare_outputs();
        check_val("ex_valid", 32'(ex_valid), 32'(exp_valid));
        check_val("ex.ctrl", 32'(ex.ctrl), 32'(exp_q.ctrl));
        check_val("ex.imm", ex.imm, exp_q.imm);
        check_val("ex.alu_src_sel", 32'(ex.alu_src_sel), 32'(exp_q.alu_src_sel));
        check_val("ex.func3", 32'(ex.func3), 32'(exp_q.func3));
        check_val("ex.rd", 32'(ex.rd), 32'(exp_q.rd));
        check_val("ex.rs1", 32'(ex.rs1), 32'(exp_q.rs1));
        check_val("ex.rs2", 32'(ex.rs2), 32'(exp_q.rs2));
        check_val("ex.rs1_val", ex.rs1_val, exp_q.rs1_val);
        check_val("ex.rs2_val", ex.rs2_val, exp_q.rs2_val);
        check_val("ex.pc", ex.pc, exp_q.pc);
    endtask

    // Next-edge expectation from the inputs that are stable now
    task automatic predict();
        rv_decode_pkg::decoded_t nxt;
        rv_decode_pkg::wb_t      w;
        w = wb;
        w.en = wb.en && (wb.rd != 5'd0);
        if (flush) begin
            exp_valid = 1'b0;
        end else if (!stall) begin
            exp_valid = instr_valid;
        end
        if (!stall) begin
            nxt = model_decode(instr);
            nxt.rs1_val = model_read(nxt.rs1, w);
            nxt.rs2_val = model_read(nxt.rs2, w);
            nxt.pc = pc;
            exp_q = nxt;
        end else begin
            if (w.en && w.rd == exp_q.rs1) begin
                exp_q.rs1_val = w.data;
            end
            if (w.en && w.rd == exp_q.rs2) begin
                exp_q.rs2_val = w.data;
            end
        end
        if (w.en) begin
            shadow[w.rd] = w.data;
        end
    endtask

    // Three edges with reset high, then the cleared state
    task automatic release_reset(input string name);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        exp_q     = '0;
        exp_valid = 1'b0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        compare_outputs();
        predict();
        $display("test %-12s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    // Opcode-biased word or a raw random word
    function automatic logic [31:0] gen_instr(input int raw_pct);
        logic [31:0] w;
        logic [3:0]  sel;
        w = rand_bits(32);
        if (rand_pct() < raw_pct) begin
            return w;
        end
        sel = 4'(rand_bits(4));
        case (sel)
            4'd0:       w[6:0] = 7'b0110111;
            4'd1:       w[6:0] = 7'b0010111;
            4'd2:       w[6:0] = 7'b1101111;
            4'd3:       w[6:0] = 7'b1100111;
            4'd4, 4'd5: w[6:0] = 7'b1100011;
            4'd6, 4'd7: w[6:0] = 7'b0000011;
            4'd8:       w[6:0] = 7'b0100011;
            4'd9, 4'd10, 4'd11: w[6:0] = 7'b0010011;
            default:    w[6:0] = 7'b0110011;
        endcase
        if (w[6:0] == 7'b0110011 || (w[6:0] == 7'b0010011 && w[12])) begin
            case (2'(rand_bits(2)))
                2'd0:    w[31:25] = 7'h00;
                2'd1:    w[31:25] = 7'h20;
                2'd2:    w[31:25] = 7'h01;
                default: w[31:25] = w[31:25]; // Keep random funct7
            endcase
        end
        return w;
    endfunction

    task automatic run_test(input string name, input int cycles, input int raw_pct,
                            input int wb_pct, input int stall_pct, input int flush_pct);
        int                 err0;
        int                 chk0;
        logic [31:0]        r;
        rv_decode_pkg::wb_t nw;
        err0 = errors;
        chk0 = checks;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            r = rand_bits(32);
            nw.en   = rand_pct() < wb_pct;
            nw.rd   = (rand_bits(3) == 32'd0) ? 5'd0 : 5'(rand_bits(5)); // Some x0 writes
            nw.data = rand_bits(32);
            instr       <= gen_instr(raw_pct);
            pc          <= {r[31:2], 2'b00};
            instr_valid <= rand_pct() < 85;
            stall       <= rand_pct() < stall_pct;
            flush       <= rand_pct() < flush_pct;
            wb          <= nw;
            @(negedge clk);
            compare_outputs();
            predict();
        end
        $display("test %-12s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        #20000;
        $display("timeout, simulation did not reach its end");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        rst         = 1'b1;
        instr       = '0;
        pc          = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb          = '0;
        exp_q       = '0;
        exp_valid   = 1'b0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        release_reset("power_on");
        run_test("decode", 600, 0, 50, 0, 0);
        @(posedge clk);
        rst         <= 1'b1;            // Registers hold written values here
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        wb          <= '0;
        release_reset("reset_mid");
        run_test("reset_state", 40, 0, 0, 0, 0);
        run_test("illegal", 300, 100, 30, 0, 0);
        run_test("stall", 500, 10, 60, 50, 0);
        run_test("flush", 400, 10, 40, 40, 25);
        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
rtl/rv_decode_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/decode_top.sv
tests/tb_decode_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_decode_top -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
